// File: src/qos_pkg.sv
package qos_pkg;

	// packet format
	localparam int num_classes = 4;
	localparam int class_w = 2;
	localparam int payload_w = 2;
	localparam int pkt_w = 4;
	localparam int bit_cnt_w = $clog2(pkt_w);
	localparam logic [bit_cnt_w-1:0] last_bit_idx = bit_cnt_w'(pkt_w - 1);

	// queue sizing
	localparam int queue_depth = 6;
	localparam int occ_w = 3;
	localparam int drop_w = 7;
	localparam logic [occ_w-1:0] occ_full = occ_w'(queue_depth);
	localparam logic [occ_w-1:0] last_slot = occ_w'(queue_depth - 1);

	// a class is served first once it holds more than its own index
	localparam logic [occ_w-1:0] serve_thresh [num_classes] = '{
		occ_w'(1),
		occ_w'(2),
		occ_w'(3),
		occ_w'(4)
	};

	// service pacing
	localparam int service_period = 32;
	localparam int tick_w = 5;
	localparam logic [tick_w-1:0] tick_last = tick_w'(service_period - 1);

	typedef enum logic [1:0] {
		sym_bad  = 2'b00, // both wires low
		sym_one  = 2'b01,
		sym_zero = 2'b10,
		sym_sep  = 2'b11
	} sym_t;

	typedef enum logic [1:0] {
		rx_idle = 2'd0,
		rx_bit  = 2'd1,
		rx_sep  = 2'd2
	} rx_state_t;

endpackage

// File: src/bit_receiver.sv
`timescale 1ns/1ps

module bit_receiver (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic line_hi,
	input  logic line_lo,
	output logic armed,
	output logic pkt_valid,
	output logic [qos_pkg::class_w-1:0] pkt_class,
	output logic [qos_pkg::payload_w-1:0] pkt_payload
);

	qos_pkg::sym_t sym;
	qos_pkg::rx_state_t state;
	logic [qos_pkg::bit_cnt_w-1:0] bit_cnt;
	logic [qos_pkg::pkt_w-2:0] shift;
	logic [qos_pkg::pkt_w-1:0] pkt;
	logic is_data;
	logic take_bit;
	logic last_bit;

	assign sym = qos_pkg::sym_t'({line_hi, line_lo}); // wire 1 is line_hi
	assign is_data = (sym == qos_pkg::sym_one) || (sym == qos_pkg::sym_zero);
	assign take_bit = (state == qos_pkg::rx_bit) && is_data;
	assign last_bit = (bit_cnt == qos_pkg::last_bit_idx);
	assign pkt = {shift, sym == qos_pkg::sym_one}; // msb arrives first
	assign armed = (state != qos_pkg::rx_idle);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= qos_pkg::rx_idle;
			bit_cnt <= '0;
			pkt_valid <= 1'b0;
		end else begin
			pkt_valid <= 1'b0;
			case (state)
				qos_pkg::rx_idle: begin
					if (start) begin
						state <= qos_pkg::rx_bit;
						bit_cnt <= '0;
					end
				end
				qos_pkg::rx_bit: begin
					if (is_data) begin
						if (last_bit) begin
							pkt_valid <= 1'b1;
							state <= qos_pkg::rx_idle; // disarm
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
							state <= qos_pkg::rx_sep;
						end
					end
				end
				qos_pkg::rx_sep: begin
					if (sym == qos_pkg::sym_sep)
						state <= qos_pkg::rx_bit; // anything else waited out
				end
				default: state <= qos_pkg::rx_idle;
			endcase
		end
	end

	// old bits fall off the shift path after a full packet
	always_ff @(posedge clk) begin
		if (take_bit) begin
			shift <= pkt[qos_pkg::pkt_w-2:0];
			if (last_bit) begin
				pkt_class <= pkt[qos_pkg::pkt_w-1 -: qos_pkg::class_w];
				pkt_payload <= pkt[qos_pkg::payload_w-1:0];
			end
		end
	end

endmodule

// File: src/service_timer.sv
`timescale 1ns/1ps

module service_timer (
	input  logic clk,
	input  logic rst,
	input  logic drain,
	output logic tick
);

	logic [qos_pkg::tick_w-1:0] count;
	logic terminal;

	assign terminal = (count == qos_pkg::tick_last);
	assign tick = drain && terminal;

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
		end else if (!drain) begin
			count <= '0; // restart period when drain drops
		end else if (terminal) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

endmodule

// File: src/class_queue.sv
`timescale 1ns/1ps

module class_queue (
	input  logic clk,
	input  logic rst,
	input  logic push,
	input  logic pop,
	input  logic [qos_pkg::payload_w-1:0] push_payload,
	output logic [qos_pkg::payload_w-1:0] head_payload,
	output logic [qos_pkg::occ_w-1:0] occupancy,
	output logic [qos_pkg::drop_w-1:0] drops
);

	logic [qos_pkg::payload_w-1:0] mem [qos_pkg::queue_depth];
	logic [qos_pkg::occ_w-1:0] rd_ptr;
	logic [qos_pkg::occ_w-1:0] wr_ptr;
	logic full;
	logic empty;
	logic do_pop;
	logic push_out;

	function automatic logic [qos_pkg::occ_w-1:0] next_ptr(
		input logic [qos_pkg::occ_w-1:0] ptr
	);
		if (ptr == qos_pkg::last_slot)
			return '0;
		return ptr + 1'b1;
	endfunction

	assign full = (occupancy == qos_pkg::occ_full);
	assign empty = (occupancy == '0);
	assign do_pop = pop && !empty;
	assign push_out = push && full && !do_pop; // oldest entry lost
	assign head_payload = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			occupancy <= '0;
			drops <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop || push_out)
				rd_ptr <= next_ptr(rd_ptr);

			if (push && !do_pop && !full)
				occupancy <= occupancy + 1'b1;
			else if (do_pop && !push)
				occupancy <= occupancy - 1'b1;

			if (push_out && drops != '1)
				drops <= drops + 1'b1; // saturating
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_payload;
	end

endmodule

// File: src/service_arbiter.sv
`timescale 1ns/1ps

module service_arbiter (
	input  logic clk,
	input  logic rst,
	input  logic tick,
	input  logic [qos_pkg::occ_w-1:0] occ_0,
	input  logic [qos_pkg::occ_w-1:0] occ_1,
	input  logic [qos_pkg::occ_w-1:0] occ_2,
	input  logic [qos_pkg::occ_w-1:0] occ_3,
	input  logic [qos_pkg::payload_w-1:0] head_0,
	input  logic [qos_pkg::payload_w-1:0] head_1,
	input  logic [qos_pkg::payload_w-1:0] head_2,
	input  logic [qos_pkg::payload_w-1:0] head_3,
	output logic pop_0,
	output logic pop_1,
	output logic pop_2,
	output logic pop_3,
	output logic out_valid,
	output logic [qos_pkg::class_w-1:0] out_class,
	output logic [qos_pkg::payload_w-1:0] out_payload
);

	logic [qos_pkg::occ_w-1:0] occ_a [qos_pkg::num_classes];
	logic [qos_pkg::payload_w-1:0] head_a [qos_pkg::num_classes];
	logic [qos_pkg::class_w-1:0] sel;
	logic sel_valid;
	logic serve;

	assign occ_a = '{occ_0, occ_1, occ_2, occ_3};
	assign head_a = '{head_0, head_1, head_2, head_3};

	always_comb begin
		sel = '0;
		sel_valid = 1'b0;
		// threshold pass from the highest class down
		for (int i = qos_pkg::num_classes - 1; i >= 0; i--) begin
			if (!sel_valid && occ_a[i] >= qos_pkg::serve_thresh[i]) begin
				sel = i[qos_pkg::class_w-1:0];
				sel_valid = 1'b1;
			end
		end
		// fallback to highest non-empty
		for (int i = qos_pkg::num_classes - 1; i >= 0; i--) begin
			if (!sel_valid && occ_a[i] != '0) begin
				sel = i[qos_pkg::class_w-1:0];
				sel_valid = 1'b1;
			end
		end
	end

	assign serve = tick && sel_valid;
	assign pop_0 = serve && (sel == 2'd0);
	assign pop_1 = serve && (sel == 2'd1);
	assign pop_2 = serve && (sel == 2'd2);
	assign pop_3 = serve && (sel == 2'd3);

	always_ff @(posedge clk) begin
		if (rst)
			out_valid <= 1'b0;
		else
			out_valid <= serve;
	end

	always_ff @(posedge clk) begin
		if (serve) begin
			out_class <= sel;
			out_payload <= head_a[sel]; // oldest entry of chosen queue
		end
	end

endmodule

// File: src/qos_buffer_top.sv
`timescale 1ns/1ps

module qos_buffer_top (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic line_hi,
	input  logic line_lo,
	input  logic drain,
	output logic armed,
	output logic out_valid,
	output logic [qos_pkg::class_w-1:0] out_class,
	output logic [qos_pkg::payload_w-1:0] out_payload,
	output logic [qos_pkg::occ_w-1:0] occ_0,
	output logic [qos_pkg::occ_w-1:0] occ_1,
	output logic [qos_pkg::occ_w-1:0] occ_2,
	output logic [qos_pkg::occ_w-1:0] occ_3,
	output logic [qos_pkg::drop_w-1:0] drops_0,
	output logic [qos_pkg::drop_w-1:0] drops_1,
	output logic [qos_pkg::drop_w-1:0] drops_2,
	output logic [qos_pkg::drop_w-1:0] drops_3
);

	logic pkt_valid;
	logic [qos_pkg::class_w-1:0] pkt_class;
	logic [qos_pkg::payload_w-1:0] pkt_payload;
	logic tick;
	logic push_0, push_1, push_2, push_3;
	logic pop_0, pop_1, pop_2, pop_3;
	logic [qos_pkg::payload_w-1:0] head_0, head_1, head_2, head_3;

	// class decode for enqueue
	assign push_0 = pkt_valid && (pkt_class == 2'd0);
	assign push_1 = pkt_valid && (pkt_class == 2'd1);
	assign push_2 = pkt_valid && (pkt_class == 2'd2);
	assign push_3 = pkt_valid && (pkt_class == 2'd3);

	bit_receiver u_rx (
		.clk(clk), .rst(rst), .start(start),
		.line_hi(line_hi), .line_lo(line_lo),
		.armed(armed), .pkt_valid(pkt_valid),
		.pkt_class(pkt_class), .pkt_payload(pkt_payload)
	);

	service_timer u_timer (.clk(clk), .rst(rst), .drain(drain), .tick(tick));

	class_queue u_queue_0 (
		.clk(clk), .rst(rst), .push(push_0), .pop(pop_0),
		.push_payload(pkt_payload), .head_payload(head_0),
		.occupancy(occ_0), .drops(drops_0)
	);

	class_queue u_queue_1 (
		.clk(clk), .rst(rst), .push(push_1), .pop(pop_1),
		.push_payload(pkt_payload), .head_payload(head_1),
		.occupancy(occ_1), .drops(drops_1)
	);

	class_queue u_queue_2 (
		.clk(clk), .rst(rst), .push(push_2), .pop(pop_2),
		.push_payload(pkt_payload), .head_payload(head_2),
		.occupancy(occ_2), .drops(drops_2)
	);

	class_queue u_queue_3 (
		.clk(clk), .rst(rst), .push(push_3), .pop(pop_3),
		.push_payload(pkt_payload), .head_payload(head_3),
		.occupancy(occ_3), .drops(drops_3)
	);

	service_arbiter u_arb (
		.clk(clk), .rst(rst), .tick(tick),
		.occ_0(occ_0), .occ_1(occ_1), .occ_2(occ_2), .occ_3(occ_3),
		.head_0(head_0), .head_1(head_1), .head_2(head_2), .head_3(head_3),
		.pop_0(pop_0), .pop_1(pop_1), .pop_2(pop_2), .pop_3(pop_3),
		.out_valid(out_valid), .out_class(out_class), .out_payload(out_payload)
	);

endmodule

// File: sim/tb_qos_buffer.sv
`timescale 1ns/1ps

module tb_qos_buffer;

	logic clk;
	logic rst;
	logic start;
	logic line_hi;
	logic line_lo;
	logic drain;
	logic armed;
	logic out_valid;
	logic [qos_pkg::class_w-1:0] out_class;
	logic [qos_pkg::payload_w-1:0] out_payload;
	logic [qos_pkg::occ_w-1:0] occ_0, occ_1, occ_2, occ_3;
	logic [qos_pkg::drop_w-1:0] drops_0, drops_1, drops_2, drops_3;

	int checks = 0;
	int value_errors = 0;
	int other_errors = 0;

	localparam int arm_timeout = 8;
	localparam int serve_timeout = 4 * qos_pkg::service_period;

	qos_buffer_top dut0 (
		.clk(clk), .rst(rst), .start(start),
		.line_hi(line_hi), .line_lo(line_lo), .drain(drain),
		.armed(armed), .out_valid(out_valid),
		.out_class(out_class), .out_payload(out_payload),
		.occ_0(occ_0), .occ_1(occ_1), .occ_2(occ_2), .occ_3(occ_3),
		.drops_0(drops_0), .drops_1(drops_1), .drops_2(drops_2), .drops_3(drops_3)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			value_errors++;
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic note_timeout(input string what);
		other_errors++;
		$display("timed out at %0t waiting for %s", $time, what);
	endtask

	task automatic reject_line(input string text);
		other_errors++;
		$display("malformed line in trace file: %s", text);
	endtask

	task automatic drive_symbol(input logic hi, input logic lo);
		@(posedge clk);
		line_hi <= hi;
		line_lo <= lo;
	endtask

	task automatic wait_armed();
		int n;
		n = 0;
		@(negedge clk);
		while (armed !== 1'b1 && n < arm_timeout) begin
			@(negedge clk);
			n++;
		end
		if (armed !== 1'b1)
			note_timeout("armed to rise");
	endtask

	task automatic send_packet(input int cls, input int pay);
		logic [qos_pkg::pkt_w-1:0] pkt;
		int extra;
		pkt = {2'(cls), 2'(pay)};
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		wait_armed();
		for (int b = qos_pkg::pkt_w - 1; b >= 0; b--) begin
			if (b != qos_pkg::pkt_w - 1) begin
				extra = $urandom % 4;
				drive_symbol(1'b1, 1'b1);
				repeat (extra) drive_symbol(1'b1, 1'b1); // spacing varies
			end
			if ($urandom % 2 == 1)
				drive_symbol(1'b0, 1'b0); // bad symbol to be ignored
			if (pkt[b])
				drive_symbol(1'b0, 1'b1);
			else
				drive_symbol(1'b1, 1'b0);
		end
		drive_symbol(1'b0, 1'b0); // last bit sampled on this edge
		@(negedge clk);
		check_value("armed", 32'(armed), 32'd0);
	endtask

	task automatic await_service(input int cls, input int pay);
		int n;
		n = 0;
		@(posedge clk);
		drain <= 1'b1;
		@(negedge clk);
		while (out_valid !== 1'b1 && n < serve_timeout) begin
			@(negedge clk);
			n++;
		end
		if (out_valid !== 1'b1) begin
			note_timeout("a served packet");
		end else begin
			check_value("out_class", 32'(out_class), 32'(cls));
			check_value("out_payload", 32'(out_payload), 32'(pay));
		end
	endtask

	task automatic watch_idle(input int periods);
		@(posedge clk);
		drain <= 1'b1;
		for (int n = 0; n < periods * qos_pkg::service_period; n++) begin
			@(negedge clk);
			if (out_valid === 1'b1) begin
				other_errors++;
				$display("out_valid pulsed at %0t although every queue was empty", $time);
			end
		end
	endtask

	task automatic verify_queues(input int e [8]);
		@(posedge clk);
		drain <= 1'b0;
		repeat (2) @(negedge clk); // enqueue lands two edges after the bit
		check_value("occ_0", 32'(occ_0), 32'(e[0]));
		check_value("occ_1", 32'(occ_1), 32'(e[1]));
		check_value("occ_2", 32'(occ_2), 32'(e[2]));
		check_value("occ_3", 32'(occ_3), 32'(e[3]));
		check_value("drops_0", 32'(drops_0), 32'(e[4]));
		check_value("drops_1", 32'(drops_1), 32'(e[5]));
		check_value("drops_2", 32'(drops_2), 32'(e[6]));
		check_value("drops_3", 32'(drops_3), 32'(e[7]));
	endtask

	initial begin
		int fd;
		int code;
		int cls;
		int pay;
		int e [8];
		string line;
		byte kind;
		bit done;
		void'($urandom(74155));
		rst = 1'b1;
		start = 1'b0;
		line_hi = 1'b0;
		line_lo = 1'b0;
		drain = 1'b0;
		done = 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_value("armed", 32'(armed), 32'd0);
		check_value("out_valid", 32'(out_valid), 32'd0);

		fd = $fopen("sim/qos_trace.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("could not open sim/qos_trace.txt");
		end else begin
			while (!done && !$feof(fd)) begin
				code = $fgets(line, fd);
				if (code == 0 || $sscanf(line, " %c", kind) != 1 || kind == "#")
					continue;
				case (kind)
					"S": begin
						if ($sscanf(line, "S %d %d", cls, pay) == 2)
							send_packet(cls, pay);
						else
							reject_line(line);
					end
					"C": begin
						code = $sscanf(line, "C %d %d %d %d %d %d %d %d",
							e[0], e[1], e[2], e[3], e[4], e[5], e[6], e[7]);
						if (code == 8)
							verify_queues(e);
						else
							reject_line(line);
					end
					"D": begin
						if ($sscanf(line, "D %d %d", cls, pay) == 2)
							await_service(cls, pay);
						else
							reject_line(line);
					end
					"Q": begin
						if ($sscanf(line, "Q %d", cls) == 1)
							watch_idle(cls);
						else
							reject_line(line);
					end
					"E": done = 1'b1;
					default: begin
						other_errors++;
						$display("unknown line in trace file: %s", line);
					end
				endcase
			end
			$fclose(fd);
			if (!done) begin
				other_errors++;
				$display("trace file ended without its end marker");
			end
		end

		$display("checks: %0d, value errors: %0d, other errors: %0d",
			checks, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0 && checks > 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: flist.f
src/qos_pkg.sv
src/bit_receiver.sv
src/service_timer.sv
src/class_queue.sv
src/service_arbiter.sv
src/qos_buffer_top.sv
sim/tb_qos_buffer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the packet buffer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_qos_buffer -f flist.f -o tb_qos_buffer

out=$(./obj_dir/tb_qos_buffer)
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
	exit 0
fi
exit 1

// File: sim/qos_trace.txt
# S class payload | C occ0 occ1 occ2 occ3 drops0 drops1 drops2 drops3
# D class payload (next served packet) | Q idle periods | E end
S 1 2
S 3 0
S 2 1
S 0 3
S 3 1
S 1 0
S 2 2
C 1 2 2 2 0 0 0 0
D 1 2
D 0 3
D 3 0
D 3 1
D 2 1
D 2 2
D 1 0
Q 3
C 0 0 0 0 0 0 0 0
S 0 0
S 0 1
S 0 2
S 0 3
S 0 0
S 0 1
S 0 2
S 0 3
S 3 3
S 3 2
S 3 1
S 3 0
S 2 1
S 2 3
S 2 0
C 6 0 3 4 2 0 0 0
D 3 3
D 2 1
D 0 2
D 0 3
D 0 0
D 0 1
D 0 2
D 0 3
D 3 2
D 3 1
D 3 0
D 2 3
D 2 0
Q 3
C 0 0 0 0 2 0 0 0
E
